// ==== logic/aes_ctrl_defs.svh ====
// AES control definitions
`ifndef AES_CTRL_DEFS_SVH
`define AES_CTRL_DEFS_SVH

// Round counter width
`define AES_RND_W 4

// Number of rounds per key length
`define AES_NR_128 4'd10
`define AES_NR_192 4'd12
`define AES_NR_256 4'd14

// Key length codes with 2'd3 left undefined
`define AES_KEY_128 2'd0
`define AES_KEY_192 2'd1
`define AES_KEY_256 2'd2

// Operation codes
`define AES_OP_FWD 1'b0
`define AES_OP_INV 1'b1

// State register input select
`define AES_STATE_ROUND 2'd0
`define AES_STATE_INIT  2'd1
`define AES_STATE_CLEAR 2'd2

// AddRoundKey input select
`define AES_ADD_RK_INIT  2'd0
`define AES_ADD_RK_ROUND 2'd1
`define AES_ADD_RK_FINAL 2'd2

// Full-key register input select
`define AES_KEY_FULL_ENC_INIT 2'd0
`define AES_KEY_FULL_DEC_INIT 2'd1
`define AES_KEY_FULL_ROUND    2'd2
`define AES_KEY_FULL_CLEAR    2'd3

// Key words feeding AddRoundKey
`define AES_KEY_WORDS_0123 2'd0
`define AES_KEY_WORDS_2345 2'd1
`define AES_KEY_WORDS_4567 2'd2
`define AES_KEY_WORDS_ZERO 2'd3

// Round key source
`define AES_ROUND_KEY_DIRECT 1'b0
`define AES_ROUND_KEY_MIXED  1'b1

`endif

// ==== logic/aes_ctrl_pkg.sv ====
// AES control types
`include "aes_ctrl_defs.svh"

package aes_ctrl_pkg;

  // Fields with a meaning of their own
  typedef logic [`AES_RND_W-1:0] rnd_ctr_t;
  typedef logic [1:0]            key_len_t;
  typedef logic                  ciph_op_t;

  // Datapath selectors
  typedef logic [1:0] state_sel_t;
  typedef logic [1:0] add_rk_sel_t;
  typedef logic [1:0] key_full_sel_t;
  typedef logic [1:0] key_words_sel_t;
  typedef logic       round_key_sel_t;

  // Main control FSM
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    INIT     = 3'd1,
    ROUND    = 3'd2,
    FINISH   = 3'd3,
    CLEAR_S  = 3'd4,
    CLEAR_KD = 3'd5,
    ERROR    = 3'd6
  } cipher_ctrl_e;

endpackage

// ==== logic/aes_ctrl_ifs.sv ====
// AES control interfaces
`timescale 1ns/1ps

////////////////////////////////////////////////////
// Command register view
////////////////////////////////////////////////////
interface aes_cmd_if;
  logic                  load;
  aes_ctrl_pkg::key_len_t key_len;
  aes_ctrl_pkg::ciph_op_t op;
  logic                  key_clear;
  logic                  data_out_clear;

  // FSM loads and the register returns the stored command
  modport fsm  (output load, input key_len, op, key_clear, data_out_clear);
  modport regs (input load, output key_len, op, key_clear, data_out_clear);
  // Key-word selector only needs the operation and key length
  modport sel  (input key_len, op);
endinterface

////////////////////////////////////////////////////
// Round sequencer control
////////////////////////////////////////////////////
interface aes_round_if;
  logic                  init;
  logic                  step;
  aes_ctrl_pkg::rnd_ctr_t rnd_ctr;
  logic                  last_regular;
  logic                  ctr_err;

  modport fsm (output init, step, input rnd_ctr, last_regular, ctr_err);
  modport seq (input init, step, output rnd_ctr, last_regular, ctr_err);
endinterface

// ==== logic/aes_cmd_reg.sv ====
// AES command register
`timescale 1ns/1ps
`include "aes_ctrl_defs.svh"

module aes_cmd_reg (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  aes_cmd_if.regs                cmd,
  input  aes_ctrl_pkg::ciph_op_t op_i,
  input  aes_ctrl_pkg::key_len_t key_len_i,
  input  logic                   key_clear_i,
  input  logic                   data_out_clear_i
);

  aes_ctrl_pkg::ciph_op_t op_q;
  aes_ctrl_pkg::key_len_t key_len_q;
  logic                   key_clear_q;
  logic                   data_out_clear_q;

  // Capture the whole command on acceptance
  // Clear flags of the previous command drop with the next load
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q             <= `AES_OP_FWD;
      key_len_q        <= `AES_KEY_128;
      key_clear_q      <= 1'b0;
      data_out_clear_q <= 1'b0;
    end else if (cmd.load) begin
      op_q             <= op_i;
      key_len_q        <= key_len_i;
      key_clear_q      <= key_clear_i;
      data_out_clear_q <= data_out_clear_i;
    end
  end

  // Forward the new op and key length in the load cycle
  // so the initial full-key select decodes the incoming command
  assign cmd.op             = cmd.load ? op_i : op_q;
  assign cmd.key_len        = cmd.load ? key_len_i : key_len_q;
  assign cmd.key_clear      = key_clear_q;
  assign cmd.data_out_clear = data_out_clear_q;

  // Every accepted command carries a defined key length
  a_key_len_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd.load |-> key_len_i inside {`AES_KEY_128, `AES_KEY_192, `AES_KEY_256});

endmodule

// ==== logic/aes_round_seq.sv ====
// AES round sequencer
`timescale 1ns/1ps
`include "aes_ctrl_defs.svh"

module aes_round_seq (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  aes_round_if.seq               rnd,
  input  aes_ctrl_pkg::key_len_t key_len_i
);

  aes_ctrl_pkg::rnd_ctr_t ctr_q;
  aes_ctrl_pkg::rnd_ctr_t total_q;
  aes_ctrl_pkg::rnd_ctr_t total_d;

  // Round total from key length
  always_comb begin
    case (key_len_i)
      `AES_KEY_128: total_d = `AES_NR_128;
      `AES_KEY_192: total_d = `AES_NR_192;
      default:      total_d = `AES_NR_256;
    endcase
  end

  // Init wins over step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q   <= '0;
      total_q <= '0;
    end else if (rnd.init) begin
      ctr_q   <= '0;
      total_q <= total_d;
    end else if (rnd.step) begin
      ctr_q   <= ctr_q + aes_ctrl_pkg::rnd_ctr_t'(1);
    end
  end

  assign rnd.rnd_ctr = ctr_q;

  // Last regular round once the counter reaches Nr-1
  assign rnd.last_regular = ctr_q >= (total_q - aes_ctrl_pkg::rnd_ctr_t'(1));

  // Counter past the total cannot happen in normal operation
  assign rnd.ctr_err = ctr_q > total_q;

  // FSM must stop stepping once all rounds are done
  a_no_step_past_total : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rnd.step |-> ctr_q != total_q);

endmodule

// ==== logic/aes_key_word_sel.sv ====
// AES key-word selector
`timescale 1ns/1ps
`include "aes_ctrl_defs.svh"

module aes_key_word_sel (
  aes_cmd_if.sel                      cmd,
  input  aes_ctrl_pkg::cipher_ctrl_e   state_i,
  output aes_ctrl_pkg::key_words_sel_t key_words_sel_o,
  output aes_ctrl_pkg::round_key_sel_t round_key_sel_o,
  output aes_ctrl_pkg::key_full_sel_t  key_full_init_sel_o
);

  logic inv;

  assign inv = cmd.op == `AES_OP_INV;

  always_comb begin
    key_words_sel_o = `AES_KEY_WORDS_ZERO;
    case (state_i)
      // Initial AddRoundKey
      aes_ctrl_pkg::INIT: begin
        case (cmd.key_len)
          `AES_KEY_128: key_words_sel_o = `AES_KEY_WORDS_0123;
          `AES_KEY_192: key_words_sel_o = inv ? `AES_KEY_WORDS_2345 : `AES_KEY_WORDS_0123;
          `AES_KEY_256: key_words_sel_o = inv ? `AES_KEY_WORDS_4567 : `AES_KEY_WORDS_0123;
          default:      key_words_sel_o = `AES_KEY_WORDS_ZERO;
        endcase
      end
      // Regular and final rounds mirror the initial selection
      aes_ctrl_pkg::ROUND, aes_ctrl_pkg::FINISH: begin
        case (cmd.key_len)
          `AES_KEY_128: key_words_sel_o = `AES_KEY_WORDS_0123;
          `AES_KEY_192: key_words_sel_o = inv ? `AES_KEY_WORDS_0123 : `AES_KEY_WORDS_2345;
          `AES_KEY_256: key_words_sel_o = inv ? `AES_KEY_WORDS_0123 : `AES_KEY_WORDS_4567;
          default:      key_words_sel_o = `AES_KEY_WORDS_ZERO;
        endcase
      end
      default: key_words_sel_o = `AES_KEY_WORDS_ZERO;
    endcase
  end

  // Equivalent inverse cipher needs MixColumns applied to the round key
  assign round_key_sel_o = (inv && state_i == aes_ctrl_pkg::ROUND) ?
                           `AES_ROUND_KEY_MIXED : `AES_ROUND_KEY_DIRECT;

  // Decryption starts from the decryption key
  assign key_full_init_sel_o = inv ? `AES_KEY_FULL_DEC_INIT : `AES_KEY_FULL_ENC_INIT;

endmodule

// ==== logic/aes_cipher_fsm.sv ====
// AES cipher control FSM
`timescale 1ns/1ps
`include "aes_ctrl_defs.svh"

module aes_cipher_fsm (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Handshakes
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,

  // Command
  input  logic                         crypt_i,
  input  logic                         key_clear_i,
  input  logic                         data_out_clear_i,
  input  aes_ctrl_pkg::ciph_op_t       op_i,
  input  aes_ctrl_pkg::key_len_t       key_len_i,

  // Errors and alert
  input  logic                         sel_err_i,
  input  logic                         alert_fatal_i,
  output logic                         alert_o,

  aes_cmd_if.fsm                       cmd,
  aes_round_if.fsm                     rnd,
  output aes_ctrl_pkg::cipher_ctrl_e   state_o,

  // Cipher datapath
  output aes_ctrl_pkg::state_sel_t     state_sel_o,
  output logic                         state_we_o,
  output aes_ctrl_pkg::add_rk_sel_t    add_rk_sel_o,
  output logic                         sub_bytes_en_o,
  input  logic                         sub_bytes_out_req_i,
  output logic                         sub_bytes_out_ack_o,

  // Key datapath
  output aes_ctrl_pkg::key_full_sel_t  key_full_sel_o,
  output logic                         key_full_we_o,
  input  aes_ctrl_pkg::key_full_sel_t  key_full_init_sel_i,
  output logic                         key_dec_clear_o,
  output logic                         key_expand_en_o,
  input  logic                         key_expand_out_req_i,
  output logic                         key_expand_out_ack_o,
  output logic                         key_expand_clear_o
);

  aes_ctrl_pkg::cipher_ctrl_e state_d, state_q;
  logic                       advance;
  logic                       clr_done_q;

  always_comb begin
    in_ready_o           = 1'b0;
    out_valid_o          = 1'b0;
    alert_o              = 1'b0;
    cmd.load             = 1'b0;
    rnd.init             = 1'b0;
    rnd.step             = 1'b0;
    state_sel_o          = `AES_STATE_ROUND;
    state_we_o           = 1'b0;
    add_rk_sel_o         = `AES_ADD_RK_ROUND;
    sub_bytes_en_o       = 1'b0;
    sub_bytes_out_ack_o  = 1'b0;
    key_full_sel_o       = `AES_KEY_FULL_ROUND;
    key_full_we_o        = 1'b0;
    key_dec_clear_o      = 1'b0;
    key_expand_en_o      = 1'b0;
    key_expand_out_ack_o = 1'b0;
    key_expand_clear_o   = 1'b0;
    advance              = 1'b0;
    state_d              = state_q;

    case (state_q)
      aes_ctrl_pkg::IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          // Clears take priority over crypt
          if (key_clear_i || data_out_clear_i) begin
            cmd.load = 1'b1;
            state_d  = data_out_clear_i ? aes_ctrl_pkg::CLEAR_S : aes_ctrl_pkg::CLEAR_KD;
          end else if (crypt_i) begin
            cmd.load           = 1'b1;
            rnd.init           = 1'b1;
            // Load input block and initial full key
            state_sel_o        = `AES_STATE_INIT;
            state_we_o         = 1'b1;
            key_full_sel_o     = key_full_init_sel_i;
            key_full_we_o      = 1'b1;
            key_expand_clear_o = 1'b1;
            state_d            = aes_ctrl_pkg::INIT;
          end else begin
            // Handshake without any command
            state_d = aes_ctrl_pkg::ERROR;
          end
        end
      end

      aes_ctrl_pkg::INIT: begin
        add_rk_sel_o = `AES_ADD_RK_INIT;
        // AES-256 has its first two round keys available right away
        if (cmd.key_len != `AES_KEY_256) begin
          key_expand_en_o = 1'b1;
          advance         = key_expand_out_req_i;
          key_expand_out_ack_o = advance;
          key_full_we_o   = advance;
        end else begin
          advance = 1'b1;
        end
        if (advance) begin
          state_we_o = 1'b1;
          rnd.step   = 1'b1;
          state_d    = aes_ctrl_pkg::ROUND;
        end
      end

      aes_ctrl_pkg::ROUND: begin
        // Step only when SubBytes and KeyExpand both have results
        sub_bytes_en_o  = 1'b1;
        key_expand_en_o = 1'b1;
        advance         = sub_bytes_out_req_i & key_expand_out_req_i;
        if (advance) begin
          sub_bytes_out_ack_o  = 1'b1;
          key_expand_out_ack_o = 1'b1;
          state_we_o           = 1'b1;
          key_full_we_o        = 1'b1;
          rnd.step             = 1'b1;
          if (rnd.last_regular) begin
            state_d = aes_ctrl_pkg::FINISH;
          end
        end
      end

      aes_ctrl_pkg::FINISH: begin
        // Final round skips MixColumns and the state is wiped on release
        add_rk_sel_o   = `AES_ADD_RK_FINAL;
        state_sel_o    = `AES_STATE_CLEAR;
        sub_bytes_en_o = 1'b1;
        // Never release data while a selector is invalid
        out_valid_o    = sub_bytes_out_req_i & ~sel_err_i;
        if (out_valid_o && out_ready_i) begin
          sub_bytes_out_ack_o = 1'b1;
          state_we_o          = 1'b1;
          state_d             = aes_ctrl_pkg::IDLE;
        end
      end

      aes_ctrl_pkg::CLEAR_S: begin
        state_sel_o = `AES_STATE_CLEAR;
        state_we_o  = 1'b1;
        state_d     = aes_ctrl_pkg::CLEAR_KD;
      end

      aes_ctrl_pkg::CLEAR_KD: begin
        // Key clear strobes fire once in the first cycle
        if (cmd.key_clear && !clr_done_q) begin
          key_full_sel_o  = `AES_KEY_FULL_CLEAR;
          key_full_we_o   = 1'b1;
          key_dec_clear_o = 1'b1;
        end
        // Pass the cleared state through to the data output
        if (cmd.data_out_clear) begin
          add_rk_sel_o = `AES_ADD_RK_INIT;
        end
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d = aes_ctrl_pkg::IDLE;
        end
      end

      aes_ctrl_pkg::ERROR: begin
        // Terminal state that only reset leaves
        alert_o = 1'b1;
      end

      default: state_d = aes_ctrl_pkg::ERROR;
    endcase

    // Escalation overrides any other transition
    if (sel_err_i || alert_fatal_i || rnd.ctr_err) begin
      state_d = aes_ctrl_pkg::ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= aes_ctrl_pkg::IDLE;
      clr_done_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      clr_done_q <= state_q == aes_ctrl_pkg::CLEAR_KD;
    end
  end

  assign state_o = state_q;

  ////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////

  a_hs_exclusive : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(in_ready_o && out_valid_o));

  // Alert only comes from ERROR and stays there
  a_alert_sticky : assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> alert_o && state_q == aes_ctrl_pkg::ERROR);

endmodule

// ==== logic/aes_cipher_ctrl.sv ====
// AES cipher control top
`timescale 1ns/1ps

module aes_cipher_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  input  logic                          crypt_i,
  input  logic                          key_clear_i,
  input  logic                          data_out_clear_i,
  input  aes_ctrl_pkg::ciph_op_t        op_i,
  input  aes_ctrl_pkg::key_len_t        key_len_i,
  input  logic                          sel_err_i,
  input  logic                          alert_fatal_i,
  output logic                          alert_o,
  output aes_ctrl_pkg::state_sel_t      state_sel_o,
  output logic                          state_we_o,
  output aes_ctrl_pkg::add_rk_sel_t     add_rk_sel_o,
  output logic                          sub_bytes_en_o,
  input  logic                          sub_bytes_out_req_i,
  output logic                          sub_bytes_out_ack_o,
  output aes_ctrl_pkg::key_full_sel_t   key_full_sel_o,
  output logic                          key_full_we_o,
  output logic                          key_dec_clear_o,
  output logic                          key_expand_en_o,
  input  logic                          key_expand_out_req_i,
  output logic                          key_expand_out_ack_o,
  output logic                          key_expand_clear_o,
  output aes_ctrl_pkg::key_words_sel_t  key_words_sel_o,
  output aes_ctrl_pkg::round_key_sel_t  round_key_sel_o,
  output aes_ctrl_pkg::rnd_ctr_t        rnd_ctr_o
);

  aes_cmd_if   cmd_if ();
  aes_round_if rnd_if ();

  aes_ctrl_pkg::cipher_ctrl_e  state;
  aes_ctrl_pkg::key_full_sel_t key_full_init_sel;

  aes_cmd_reg i_cmd_reg (
    .clk_i, .rst_ni,
    .cmd              (cmd_if.regs),
    .op_i, .key_len_i, .key_clear_i, .data_out_clear_i
  );

  // Round total comes straight from the command in the acceptance cycle
  aes_round_seq i_round_seq (
    .clk_i, .rst_ni,
    .rnd       (rnd_if.seq),
    .key_len_i
  );

  aes_key_word_sel i_key_word_sel (
    .cmd                 (cmd_if.sel),
    .state_i             (state),
    .key_words_sel_o,
    .round_key_sel_o,
    .key_full_init_sel_o (key_full_init_sel)
  );

  aes_cipher_fsm i_fsm (
    .clk_i, .rst_ni,
    .in_valid_i, .in_ready_o, .out_valid_o, .out_ready_i,
    .crypt_i, .key_clear_i, .data_out_clear_i, .op_i, .key_len_i,
    .sel_err_i, .alert_fatal_i, .alert_o,
    .cmd                 (cmd_if.fsm),
    .rnd                 (rnd_if.fsm),
    .state_o             (state),
    .state_sel_o, .state_we_o, .add_rk_sel_o,
    .sub_bytes_en_o, .sub_bytes_out_req_i, .sub_bytes_out_ack_o,
    .key_full_sel_o, .key_full_we_o,
    .key_full_init_sel_i (key_full_init_sel),
    .key_dec_clear_o, .key_expand_en_o, .key_expand_out_req_i,
    .key_expand_out_ack_o, .key_expand_clear_o
  );

  assign rnd_ctr_o = rnd_if.rnd_ctr;

endmodule

// ==== tests/tb_aes_cipher_ctrl.sv ====
// AES cipher control testbench
`timescale 1ns/1ps
`include "aes_ctrl_defs.svh"

module tb_aes_cipher_ctrl;

  // Watchdog limit is twice 12 tests of 14 rounds x 4 cycles + 8 stall cycles
  localparam int NUM_TESTS       = 12;
  localparam int CASE_CYCLES     = 14 * 4 + 8;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * CASE_CYCLES * 2;

  logic clk_i;
  logic rst_ni;
  logic in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  logic crypt_i, key_clear_i, data_out_clear_i;
  aes_ctrl_pkg::ciph_op_t op_i;
  aes_ctrl_pkg::key_len_t key_len_i;
  logic sel_err_i, alert_fatal_i, alert_o;
  aes_ctrl_pkg::state_sel_t state_sel_o;
  logic state_we_o;
  aes_ctrl_pkg::add_rk_sel_t add_rk_sel_o;
  logic sub_bytes_en_o, sub_bytes_out_ack_o;
  logic sub_bytes_out_req_i = 1'b0;
  aes_ctrl_pkg::key_full_sel_t key_full_sel_o;
  logic key_full_we_o, key_dec_clear_o, key_expand_en_o;
  logic key_expand_out_ack_o, key_expand_clear_o;
  logic key_expand_out_req_i = 1'b0;
  aes_ctrl_pkg::key_words_sel_t key_words_sel_o;
  aes_ctrl_pkg::round_key_sel_t round_key_sel_o;
  aes_ctrl_pkg::rnd_ctr_t rnd_ctr_o;

  logic [31:0] lfsr_q = 32'hbc01_1169;
  int errors = 0;
  int sb_acks = 0;
  int ke_acks = 0;
  int sb_wait = 0;
  int ke_wait = 0;
  logic check_sel = 1'b0;
  logic allow_alert = 1'b0;
  aes_ctrl_pkg::ciph_op_t exp_op = `AES_OP_FWD;
  aes_ctrl_pkg::key_len_t exp_kl = `AES_KEY_128;
  aes_ctrl_pkg::key_full_sel_t acc_kf_sel;
  logic acc_kf_we, acc_st_we, acc_ke_clr;
  aes_ctrl_pkg::state_sel_t acc_st_sel;

  aes_cipher_ctrl i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Galois LFSR with taps 32, 31, 29 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val    = (val << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic failure(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  // Rounds per key length
  function automatic int rounds_for(input aes_ctrl_pkg::key_len_t kl);
    if (kl == `AES_KEY_128) return 10;
    if (kl == `AES_KEY_192) return 12;
    return 14;
  endfunction

  // Key words feeding AddRoundKey in the initial phase or in later rounds
  function automatic logic [1:0] words_for(input logic op, input logic [1:0] kl,
                                           input logic init_phase);
    logic inv;
    inv = op == `AES_OP_INV;
    if (kl == `AES_KEY_128) return `AES_KEY_WORDS_0123;
    if (kl == `AES_KEY_192) begin
      return (inv == init_phase) ? `AES_KEY_WORDS_2345 : `AES_KEY_WORDS_0123;
    end
    return (inv == init_phase) ? `AES_KEY_WORDS_4567 : `AES_KEY_WORDS_0123;
  endfunction

  //////////////////////////////////////////////////
  // Datapath responder
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      sub_bytes_out_req_i  <= 1'b0;
      key_expand_out_req_i <= 1'b0;
      sb_wait = 0;
      ke_wait = 0;
    end else begin
      // Request drops once acknowledged and a fresh delay is drawn
      if (sub_bytes_out_req_i && sub_bytes_out_ack_o) begin
        sub_bytes_out_req_i <= 1'b0;
        take_bits(2, sb_wait);
      end else if (!sub_bytes_out_req_i && sub_bytes_en_o) begin
        if (sb_wait == 0) sub_bytes_out_req_i <= 1'b1;
        else sb_wait--;
      end
      if (key_expand_out_req_i && key_expand_out_ack_o) begin
        key_expand_out_req_i <= 1'b0;
        take_bits(2, ke_wait);
      end else if (!key_expand_out_req_i && key_expand_en_o) begin
        if (ke_wait == 0) key_expand_out_req_i <= 1'b1;
        else ke_wait--;
      end
    end
  end

  // Ack counting and selector checks at every acknowledge
  // INIT acks only KeyExpand and FINISH acks only SubBytes
  always @(posedge clk_i) begin
    logic       init_ph;
    logic       fin_ph;
    logic [1:0] exp_words;
    logic [1:0] exp_add_rk;
    logic       exp_rk_sel;
    if (rst_ni) begin
      if (sub_bytes_out_ack_o) sb_acks++;
      if (key_expand_out_ack_o) ke_acks++;
      if (check_sel && (sub_bytes_out_ack_o || key_expand_out_ack_o)) begin
        init_ph    = !sub_bytes_out_ack_o;
        fin_ph     = !key_expand_out_ack_o;
        exp_words  = words_for(exp_op, exp_kl, init_ph);
        exp_add_rk = init_ph ? `AES_ADD_RK_INIT :
                     (fin_ph ? `AES_ADD_RK_FINAL : `AES_ADD_RK_ROUND);
        exp_rk_sel = (exp_op == `AES_OP_INV && !init_ph && !fin_ph) ?
                     `AES_ROUND_KEY_MIXED : `AES_ROUND_KEY_DIRECT;
        if (key_words_sel_o !== exp_words)
          mismatch("key_words_sel_o", 32'(key_words_sel_o), 32'(exp_words));
        if (round_key_sel_o !== exp_rk_sel)
          mismatch("round_key_sel_o", 32'(round_key_sel_o), 32'(exp_rk_sel));
        if (add_rk_sel_o !== exp_add_rk)
          mismatch("add_rk_sel_o", 32'(add_rk_sel_o), 32'(exp_add_rk));
      end
      if (alert_o && !allow_alert) failure("Alert raised without an error");
    end
  end

  //////////////////////////////////////////////////
  // Command and result tasks
  //////////////////////////////////////////////////

  task automatic send_cmd(input logic crypt, input logic kclr, input logic dclr,
                          input logic op, input logic [1:0] kl, output logic ok);
    int n;
    in_valid_i       <= 1'b1;
    crypt_i          <= crypt;
    key_clear_i      <= kclr;
    data_out_clear_i <= dclr;
    op_i             <= op;
    key_len_i        <= kl;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < 100) begin
      @(posedge clk_i);
      n++;
      if (in_valid_i && in_ready_o) begin
        ok         = 1'b1;
        acc_kf_sel = key_full_sel_o;
        acc_kf_we  = key_full_we_o;
        acc_st_we  = state_we_o;
        acc_st_sel = state_sel_o;
        acc_ke_clr = key_expand_clear_o;
      end
    end
    in_valid_i       <= 1'b0;
    crypt_i          <= 1'b0;
    key_clear_i      <= 1'b0;
    data_out_clear_i <= 1'b0;
    if (!ok) failure("Command was not accepted within 100 cycles");
  endtask

  task automatic wait_result(output logic ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < 200) begin
      @(posedge clk_i);
      n++;
      ok = out_valid_o;
    end
    if (!ok) failure("No result within 200 cycles");
  endtask

  // Stall for hold cycles and then take exactly one result
  task automatic release_output(input int hold, input logic quiet);
    int n;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk_i);
      if (out_valid_o !== 1'b1) mismatch("out_valid_o", 32'(out_valid_o), 32'h1);
      if (quiet && (state_we_o || key_full_we_o || sub_bytes_out_ack_o ||
                    key_expand_out_ack_o))
        failure("Strobe fired while the output was stalled");
    end
    out_ready_i <= 1'b1;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!(out_valid_o && out_ready_i) && n < 50);
    out_ready_i <= 1'b0;
    if (n >= 50) failure("Result was never released");
    @(posedge clk_i);
    if (out_valid_o !== 1'b0) mismatch("out_valid_o", 32'(out_valid_o), 32'h0);
    if (in_ready_o !== 1'b1) mismatch("in_ready_o", 32'(in_ready_o), 32'h1);
  endtask

  task automatic apply_reset();
    rst_ni <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  // Round count, key words and optional back-pressure for one crypt
  task automatic run_crypt(input logic op, input logic [1:0] kl, input int hold);
    int sb0, ke0, nr, ke_exp;
    logic ok;
    exp_op    = op;
    exp_kl    = kl;
    check_sel = 1'b1;
    sb0 = sb_acks;
    ke0 = ke_acks;
    nr  = rounds_for(kl);
    ke_exp = (kl == `AES_KEY_256) ? nr - 1 : nr;
    send_cmd(1'b1, 1'b0, 1'b0, op, kl, ok);
    if (ok) begin
      if (acc_kf_sel !== ((op == `AES_OP_INV) ? `AES_KEY_FULL_DEC_INIT : `AES_KEY_FULL_ENC_INIT))
        mismatch("key_full_sel_o", 32'(acc_kf_sel), 32'(op));
      if (!acc_kf_we || !acc_st_we || !acc_ke_clr)
        failure("Acceptance cycle missed a load strobe");
      if (acc_st_sel !== `AES_STATE_INIT)
        mismatch("state_sel_o", 32'(acc_st_sel), 32'(`AES_STATE_INIT));
      wait_result(ok);
      if (ok) begin
        if (int'(rnd_ctr_o) != nr) mismatch("rnd_ctr_o", 32'(rnd_ctr_o), 32'(nr));
        release_output(hold, 1'b1);
      end
    end
    if (sb_acks - sb0 != nr) mismatch("sub_bytes_out_ack_o count", 32'(sb_acks - sb0), 32'(nr));
    if (ke_acks - ke0 != ke_exp)
      mismatch("key_expand_out_ack_o count", 32'(ke_acks - ke0), 32'(ke_exp));
    check_sel = 1'b0;
  endtask

  task automatic clear_key();
    logic ok;
    send_cmd(1'b0, 1'b1, 1'b0, `AES_OP_FWD, `AES_KEY_128, ok);
    @(posedge clk_i);
    if (key_full_we_o !== 1'b1 || key_dec_clear_o !== 1'b1)
      failure("Key clear strobes missing");
    if (key_full_sel_o !== `AES_KEY_FULL_CLEAR)
      mismatch("key_full_sel_o", 32'(key_full_sel_o), 32'(`AES_KEY_FULL_CLEAR));
    if (out_valid_o !== 1'b1) mismatch("out_valid_o", 32'(out_valid_o), 32'h1);
    release_output(0, 1'b0);
  endtask

  task automatic clear_data_out();
    logic ok;
    send_cmd(1'b0, 1'b0, 1'b1, `AES_OP_FWD, `AES_KEY_128, ok);
    @(posedge clk_i);
    if (state_we_o !== 1'b1) mismatch("state_we_o", 32'(state_we_o), 32'h1);
    if (state_sel_o !== `AES_STATE_CLEAR)
      mismatch("state_sel_o", 32'(state_sel_o), 32'(`AES_STATE_CLEAR));
    if (out_valid_o !== 1'b0) mismatch("out_valid_o", 32'(out_valid_o), 32'h0);
    @(posedge clk_i);
    if (out_valid_o !== 1'b1) mismatch("out_valid_o", 32'(out_valid_o), 32'h1);
    release_output(0, 1'b0);
  endtask

  // Selector error mid-round must lock the FSM up
  task automatic error_escalation();
    logic ok;
    int n;
    allow_alert = 1'b1;
    send_cmd(1'b1, 1'b0, 1'b0, `AES_OP_FWD, `AES_KEY_128, ok);
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!(sub_bytes_en_o && add_rk_sel_o == `AES_ADD_RK_ROUND) && n < 50);
    if (n >= 50) failure("Cipher never reached a regular round");
    sel_err_i <= 1'b1;
    @(posedge clk_i);
    sel_err_i <= 1'b0;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk_i);
      if (out_valid_o !== 1'b0) mismatch("out_valid_o", 32'(out_valid_o), 32'h0);
      if (in_ready_o !== 1'b0) mismatch("in_ready_o", 32'(in_ready_o), 32'h0);
    end
    if (alert_o !== 1'b1) mismatch("alert_o", 32'(alert_o), 32'h1);
    apply_reset();
    allow_alert = 1'b0;
  endtask

  task automatic empty_handshake();
    logic ok;
    allow_alert = 1'b1;
    send_cmd(1'b0, 1'b0, 1'b0, `AES_OP_FWD, `AES_KEY_128, ok);
    repeat (2) @(posedge clk_i);
    if (alert_o !== 1'b1) mismatch("alert_o", 32'(alert_o), 32'h1);
    apply_reset();
    allow_alert = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    int hold;
    rst_ni           = 1'b0;
    in_valid_i       = 1'b0;
    out_ready_i      = 1'b0;
    crypt_i          = 1'b0;
    key_clear_i      = 1'b0;
    data_out_clear_i = 1'b0;
    op_i             = `AES_OP_FWD;
    key_len_i        = `AES_KEY_128;
    sel_err_i        = 1'b0;
    alert_fatal_i    = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    for (int k = 0; k < 3; k++) begin
      for (int o = 0; o < 2; o++) begin
        take_bits(2, hold);
        run_crypt(o[0], k[1:0], hold);
      end
    end
    run_crypt(`AES_OP_FWD, `AES_KEY_256, 8);
    clear_key();
    clear_data_out();
    error_escalation();
    run_crypt(`AES_OP_INV, `AES_KEY_192, 1);
    empty_handshake();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, errors so far: %0d", WATCHDOG_CYCLES, errors);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/aes_ctrl_pkg.sv
logic/aes_ctrl_ifs.sv
logic/aes_cmd_reg.sv
logic/aes_round_seq.sv
logic/aes_key_word_sel.sv
logic/aes_cipher_fsm.sv
logic/aes_cipher_ctrl.sv
tests/tb_aes_cipher_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the AES cipher control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_aes_cipher_ctrl \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  exit 0
fi
exit 1
